//--- verilog/aib_data_pkg.sv
/*
 * data path definitions for the adapter channel
 * widths, MAC word type and the IO word struct
 */

`default_nettype none

package aib_data_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int MAC_W     = 32;              // MAC data word
    localparam int DBI_BYTES = 4;               // one inversion flag per byte
    localparam int BYTE_W    = MAC_W / DBI_BYTES;
    localparam int IO_W      = 1 + DBI_BYTES + MAC_W;

    typedef logic [MAC_W-1:0] mac_word_t;

    // word on the AIB IO buffers
    // marker sits on the top bit, data on the bottom
    typedef struct packed {
        logic                 marker;           // set on data words
        logic [DBI_BYTES-1:0] dbi;              // byte i inverted when set
        mac_word_t            data;
    } io_word_t;

endpackage

`default_nettype wire

//--- verilog/aib_ctrl_pkg.sv
/*
 * control definitions for the adapter channel
 * FIFO depths, credit width, loopback modes
 */

`default_nettype none

package aib_ctrl_pkg;

    localparam int TX_DEPTH = 4;                // also the MAC's initial tx credits
    localparam int RX_DEPTH = 4;
    localparam int CREDIT_W = 4;                // rx credit counter

    // csr_lpbk_mode encoding, unlisted codes behave as LPBK_NONE
    typedef enum logic [1:0] {
        LPBK_NONE     = 2'd0,
        LPBK_NEARSIDE = 2'd2
    } lpbk_mode_t;

endpackage

`default_nettype wire

//--- verilog/aib_word_fifo.sv
/*
 * synchronous FIFO with a type parameter for the payload
 * show-ahead read, pointer pair plus occupancy count
 */

`timescale 1ns/1ps
`default_nettype none

module aib_word_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     m_fs_fwd_clk,
    input  wire logic     reset,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      pop_data,
    output logic          empty,
    output logic          full
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    payload_t mem [DEPTH];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    cnt_t     count;

    assign empty    = (count == '0);
    assign full     = (count == cnt_t'(DEPTH));
    assign pop_data = mem[rd_ptr];              // head word, valid when !empty

    // storage
    always_ff @(posedge m_fs_fwd_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and occupancy
    always_ff @(posedge m_fs_fwd_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_t'(push) - cnt_t'(pop);
        end
    end

    // callers must gate push and pop with the flags
    a_no_ovf_unf: assert property (@(posedge m_fs_fwd_clk) disable iff (reset)
        !(push && full) && !(pop && empty));

endmodule

`default_nettype wire

//--- verilog/aib_tx_chnl.sv
/*
 * transmit input side of the adapter channel
 * MAC words under credit flow control, buffered in a FIFO
 * one word per cycle out to the DBI encoder, credit back per pop
 */

`timescale 1ns/1ps
`default_nettype none

module aib_tx_chnl
    import aib_data_pkg::*;
    import aib_ctrl_pkg::*;
(
    input  wire logic      m_fs_fwd_clk,
    input  wire logic      reset,
    input  wire logic      mac_tx_valid,
    input  wire mac_word_t mac_tx_data,
    output logic           mac_tx_credit,
    output logic           enc_valid,
    output mac_word_t      enc_data
);

    logic      tx_pop;
    logic      tx_empty;
    logic      tx_full;
    mac_word_t tx_head;

    ////////////////////
    // buffer
    ////////////////////
    aib_word_fifo #(
        .payload_t (mac_word_t),
        .DEPTH     (TX_DEPTH)
    ) tx_fifo_inst (
        .m_fs_fwd_clk (m_fs_fwd_clk),
        .reset        (reset),
        .push         (mac_tx_valid),       // every word has a credit behind it
        .push_data    (mac_tx_data),
        .pop          (tx_pop),
        .pop_data     (tx_head),
        .empty        (tx_empty),
        .full         (tx_full)
    );

    assign tx_pop = !tx_empty;              // no back-pressure toward the IO

    ////////////////////
    // output registers
    ////////////////////
    always_ff @(posedge m_fs_fwd_clk) begin
        if (reset) begin
            enc_valid     <= 1'b0;
            mac_tx_credit <= 1'b0;
        end else begin
            enc_valid     <= tx_pop;
            mac_tx_credit <= tx_pop;        // slot freed, one credit back
        end
    end

    always_ff @(posedge m_fs_fwd_clk) begin
        if (tx_pop) begin
            enc_data <= tx_head;
        end
    end

    // sender overran its credits
    a_tx_credit: assert property (@(posedge m_fs_fwd_clk) disable iff (reset)
        !(mac_tx_valid && tx_full));

endmodule

`default_nettype wire

//--- verilog/aib_dbi_enc.sv
/*
 * DBI encoder and IO output register
 * inverts bytes with more than four ones and sets the marker
 */

`timescale 1ns/1ps
`default_nettype none

module aib_dbi_enc
    import aib_data_pkg::*;
(
    input  wire logic      m_fs_fwd_clk,
    input  wire logic      reset,
    input  wire logic      enc_valid,
    input  wire mac_word_t enc_data,
    input  wire logic      csr_tx_dbi_en,
    output io_word_t       aibio_dout
);

    io_word_t enc_word;

    // per byte inversion decision
    always_comb begin
        enc_word = '0;                      // idle word is all zero
        if (enc_valid) begin
            enc_word.marker = 1'b1;
            for (int i = 0; i < DBI_BYTES; i++) begin
                if (csr_tx_dbi_en && ($countones(enc_data[BYTE_W*i +: BYTE_W]) > 4)) begin
                    enc_word.dbi[i]                   = 1'b1;
                    enc_word.data[BYTE_W*i +: BYTE_W] = ~enc_data[BYTE_W*i +: BYTE_W];
                end else begin
                    enc_word.data[BYTE_W*i +: BYTE_W] = enc_data[BYTE_W*i +: BYTE_W];
                end
            end
        end
    end

    always_ff @(posedge m_fs_fwd_clk) begin
        if (reset) begin
            aibio_dout <= '0;
        end else begin
            aibio_dout <= enc_word;
        end
    end

    // no inversion flags on idle words or with DBI off
    a_dbi_flags: assert property (@(posedge m_fs_fwd_clk) disable iff (reset)
        (!enc_valid || !csr_tx_dbi_en) |=> (aibio_dout.dbi == '0));

endmodule

`default_nettype wire

//--- verilog/aib_rx_chnl.sv
/*
 * receive output side of the adapter channel
 * loopback select, idle drop, align flag, DBI decode
 * receive FIFO with overflow flag, credit-gated delivery to the MAC
 */

`timescale 1ns/1ps
`default_nettype none

module aib_rx_chnl
    import aib_data_pkg::*;
    import aib_ctrl_pkg::*;
(
    input  wire logic       m_fs_fwd_clk,
    input  wire logic       reset,
    input  wire io_word_t   aibio_din,
    input  wire io_word_t   lpbk_word,
    input  wire lpbk_mode_t csr_lpbk_mode,
    input  wire logic       csr_rx_dbi_en,
    input  wire logic       mac_rx_credit,
    output logic            mac_rx_valid,
    output mac_word_t       mac_rx_data,
    output logic            m_rx_align_done,
    output logic            rx_overflow
);

    io_word_t            in_word;
    mac_word_t           dec_data;
    logic                rx_push;
    logic                rx_pop;
    logic                rx_empty;
    logic                rx_full;
    mac_word_t           rx_head;
    logic [CREDIT_W-1:0] credit_cnt;

    ////////////////////
    // input stage
    ////////////////////
    always_ff @(posedge m_fs_fwd_clk) begin
        if (reset) begin
            in_word <= '0;
        end else if (csr_lpbk_mode == LPBK_NEARSIDE) begin
            in_word <= lpbk_word;           // own tx output
        end else begin
            in_word <= aibio_din;
        end
    end

    // first marked word means the link is aligned
    always_ff @(posedge m_fs_fwd_clk) begin
        if (reset) begin
            m_rx_align_done <= 1'b0;
            rx_overflow     <= 1'b0;
        end else begin
            if (in_word.marker) begin
                m_rx_align_done <= 1'b1;
            end
            if (in_word.marker && rx_full) begin
                rx_overflow <= 1'b1;        // sticky until reset
            end
        end
    end

    ////////////////////
    // decode and buffer
    ////////////////////
    always_comb begin
        for (int i = 0; i < DBI_BYTES; i++) begin
            dec_data[BYTE_W*i +: BYTE_W] = (csr_rx_dbi_en && in_word.dbi[i]) ?
                ~in_word.data[BYTE_W*i +: BYTE_W] : in_word.data[BYTE_W*i +: BYTE_W];
        end
    end

    assign rx_push = in_word.marker && !rx_full;    // idle words never stored

    aib_word_fifo #(
        .payload_t (mac_word_t),
        .DEPTH     (RX_DEPTH)
    ) rx_fifo_inst (
        .m_fs_fwd_clk (m_fs_fwd_clk),
        .reset        (reset),
        .push         (rx_push),
        .push_data    (dec_data),
        .pop          (rx_pop),
        .pop_data     (rx_head),
        .empty        (rx_empty),
        .full         (rx_full)
    );

    ////////////////////
    // delivery
    ////////////////////
    assign rx_pop = !rx_empty && (credit_cnt != '0);

    always_ff @(posedge m_fs_fwd_clk) begin
        if (reset) begin
            credit_cnt   <= '0;
            mac_rx_valid <= 1'b0;
        end else begin
            credit_cnt   <= credit_cnt + CREDIT_W'(mac_rx_credit) - CREDIT_W'(rx_pop);
            mac_rx_valid <= rx_pop;
        end
    end

    always_ff @(posedge m_fs_fwd_clk) begin
        if (rx_pop) begin
            mac_rx_data <= rx_head;
        end
    end

    // MAC may not grant more credits than the counter holds
    a_credit_wrap: assert property (@(posedge m_fs_fwd_clk) disable iff (reset)
        (mac_rx_credit && !rx_pop && (credit_cnt == '1)) |=> 1'b0);

endmodule

`default_nettype wire

//--- verilog/aib_adapt_chnl.sv
/*
 * adapter channel top level
 * tx channel, DBI encoder and rx channel behind plain ports
 */

`timescale 1ns/1ps
`default_nettype none

module aib_adapt_chnl
    import aib_data_pkg::*;
    import aib_ctrl_pkg::*;
(
    input  wire logic             m_fs_fwd_clk,
    input  wire logic             reset,
    // MAC transmit
    input  wire logic             mac_tx_valid,
    input  wire logic [MAC_W-1:0] mac_tx_data,
    output logic                  mac_tx_credit,
    // AIB IO
    output logic [IO_W-1:0]       aibio_dout,
    input  wire logic [IO_W-1:0]  aibio_din,
    // MAC receive
    input  wire logic             mac_rx_credit,
    output logic                  mac_rx_valid,
    output logic [MAC_W-1:0]      mac_rx_data,
    output logic                  m_rx_align_done,
    output logic                  rx_overflow,
    // csr
    input  wire logic             csr_tx_dbi_en,
    input  wire logic             csr_rx_dbi_en,
    input  wire logic [1:0]       csr_lpbk_mode
);

    logic      enc_valid;
    mac_word_t enc_data;
    io_word_t  tx_io_word;                  // encoder output, also the loopback source

    aib_tx_chnl tx_chnl_inst (
        .m_fs_fwd_clk  (m_fs_fwd_clk),
        .reset         (reset),
        .mac_tx_valid  (mac_tx_valid),
        .mac_tx_data   (mac_tx_data),
        .mac_tx_credit (mac_tx_credit),
        .enc_valid     (enc_valid),
        .enc_data      (enc_data)
    );

    aib_dbi_enc dbi_enc_inst (
        .m_fs_fwd_clk  (m_fs_fwd_clk),
        .reset         (reset),
        .enc_valid     (enc_valid),
        .enc_data      (enc_data),
        .csr_tx_dbi_en (csr_tx_dbi_en),
        .aibio_dout    (tx_io_word)
    );

    assign aibio_dout = tx_io_word;

    aib_rx_chnl rx_chnl_inst (
        .m_fs_fwd_clk    (m_fs_fwd_clk),
        .reset           (reset),
        .aibio_din       (io_word_t'(aibio_din)),
        .lpbk_word       (tx_io_word),      // near-side loopback path
        .csr_lpbk_mode   (lpbk_mode_t'(csr_lpbk_mode)),
        .csr_rx_dbi_en   (csr_rx_dbi_en),
        .mac_rx_credit   (mac_rx_credit),
        .mac_rx_valid    (mac_rx_valid),
        .mac_rx_data     (mac_rx_data),
        .m_rx_align_done (m_rx_align_done),
        .rx_overflow     (rx_overflow)
    );

endmodule

`default_nettype wire

//--- include/aib_tb_vectors.svh
/*
 * stimulus and expected values for the adapter channel testbench
 * one row per test, applied in order
 */

`ifndef AIB_TB_VECTORS_SVH
`define AIB_TB_VECTORS_SVH

typedef struct packed {
    logic [8*12-1:0] name;
    logic            dbi_en;        // tx and rx DBI enable
    logic [1:0]      mode;          // csr_lpbk_mode
    int              n_words;
    int              seed_ofs;      // added to the base seed
    logic            hold_cred;     // no rx credits until every word has arrived
    int              exp_rx;        // words expected at the MAC
    logic            exp_ovf;
} test_vec_t;

localparam int num_tests = 5;

// columns: name, dbi, loopback mode, words, seed offset, hold credits,
// expected rx words, expected overflow
localparam test_vec_t test_table [num_tests] = '{
    '{"lpbk_dbi",    1'b1, LPBK_NEARSIDE, 12,           0, 1'b0, 12,       1'b0},
    '{"lpbk_nodbi",  1'b0, LPBK_NEARSIDE, 10,           1, 1'b0, 10,       1'b0},
    '{"ext_rx_dbi",  1'b1, LPBK_NONE,     8,            2, 1'b0, 8,        1'b0},
    '{"ext_mode1",   1'b0, 2'd1,          8,            3, 1'b0, 8,        1'b0},
    '{"rx_backpres", 1'b1, LPBK_NEARSIDE, RX_DEPTH + 2, 4, 1'b1, RX_DEPTH, 1'b1}
};

`endif

//--- test/aib_adapt_tb.sv
/*
 * testbench for the adapter channel
 * table-driven loopback and external receive tests
 * tx credit model, io encoding and receive scoreboards
 */

`timescale 1ns/1ps
`default_nettype none

module aib_adapt_tb
    import aib_data_pkg::*;
    import aib_ctrl_pkg::*;
();

`include "aib_tb_vectors.svh"

    logic             m_fs_fwd_clk;
    logic             reset;
    logic             mac_tx_valid;
    logic [MAC_W-1:0] mac_tx_data;
    logic             mac_tx_credit;
    logic [IO_W-1:0]  aibio_dout;
    logic [IO_W-1:0]  aibio_din;
    logic             mac_rx_credit;
    logic             mac_rx_valid;
    logic [MAC_W-1:0] mac_rx_data;
    logic             m_rx_align_done;
    logic             rx_overflow;
    logic             csr_tx_dbi_en;
    logic             csr_rx_dbi_en;
    logic [1:0]       csr_lpbk_mode;

    int        seed;
    int        err_data;                    // wrong words at the MAC
    int        err_enc;                     // wrong words on aibio_dout
    int        err_ctrl;
    bit        timed_out;
    mac_word_t words [32];

    aib_adapt_chnl aib_adapt_chnl_inst (.*);

    initial begin
        m_fs_fwd_clk = 1'b0;
        forever #50 m_fs_fwd_clk = ~m_fs_fwd_clk;
    end

    // expected IO word with bytes of more than four ones inverted
    function automatic io_word_t dbi_encode(input mac_word_t w, input logic en);
        io_word_t r;
        int       ones;
        r.marker = 1'b1;
        r.dbi    = '0;
        r.data   = w;
        for (int b = 0; b < DBI_BYTES; b++) begin
            ones = 0;
            for (int k = 0; k < 8; k++) begin
                if (w[8*b+k]) begin
                    ones++;
                end
            end
            if (en && ones > 4) begin
                r.dbi[b]         = 1'b1;
                r.data[8*b +: 8] = ~w[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic reset_and_check(input logic [8*12-1:0] name);
        logic [3:0] ctrl;
        @(negedge m_fs_fwd_clk);
        reset         = 1'b1;
        mac_tx_valid  = 1'b0;
        aibio_din     = '0;
        mac_rx_credit = 1'b0;
        repeat (4) @(negedge m_fs_fwd_clk);
        reset = 1'b0;
        @(negedge m_fs_fwd_clk);
        ctrl = {mac_tx_credit, mac_rx_valid, m_rx_align_done, rx_overflow};
        assert (ctrl == 4'b0000) else begin
            $display("ERR %0s: reset controls expected %b actual %b", name, 4'b0000, ctrl);
            err_ctrl++;
        end
        assert (aibio_dout == '0) else begin
            $display("ERR %0s: reset aibio_dout expected %h actual %h", name, {IO_W{1'b0}},
                aibio_dout);
            err_ctrl++;
        end
    endtask

    ////////////////////
    // one table row
    ////////////////////
    task automatic run_test(input test_vec_t v);
        bit       tx_side;
        bit       done = 1'b0;
        int       sent = 0;
        int       enc_idx = 0;
        int       rcvd = 0;
        int       grants = 0;
        int       tx_cred = TX_DEPTH;       // MAC credits after reset
        int       settle = 0;
        int       drain = 0;
        int       cycles = 0;
        int       since_mark = -1;          // cycles since the first marked rx input word
        io_word_t exp_io;
        io_word_t got_io;
        $display("test %0s", v.name);
        tx_side = (v.mode == LPBK_NEARSIDE);
        seed    = 56632 + v.seed_ofs;
        for (int i = 0; i < v.n_words; i++) begin
            words[i] = $random(seed);
        end
        csr_tx_dbi_en = v.dbi_en;
        csr_rx_dbi_en = v.dbi_en;
        csr_lpbk_mode = v.mode;
        reset_and_check(v.name);
        while (!done && !timed_out) begin
            @(negedge m_fs_fwd_clk);        // outputs settled since the rising edge
            cycles++;
            if (since_mark >= 0) begin
                since_mark++;
            end
            if (mac_tx_credit) begin
                tx_cred++;
            end
            assert (tx_cred >= 0 && tx_cred <= TX_DEPTH) else begin
                $display("%0s: tx credit count out of range at %0d", v.name, tx_cred);
                err_ctrl++;
            end
            // input register, then the align flag one edge later
            assert (m_rx_align_done == (since_mark >= 2)) else begin
                $display("ERR %0s: align flag expected %0b actual %0b", v.name,
                    since_mark >= 2, m_rx_align_done);
                err_ctrl++;
            end
            got_io = io_word_t'(aibio_dout);
            if (got_io.marker) begin
                assert (tx_side && enc_idx < v.n_words) else begin
                    $display("%0s: unexpected marked word on aibio_dout", v.name);
                    err_enc++;
                end
                if (tx_side && enc_idx < v.n_words) begin
                    exp_io = dbi_encode(words[enc_idx], v.dbi_en);
                    assert (got_io == exp_io) else begin
                        $display("ERR %0s: io word %0d expected %h actual %h", v.name, enc_idx,
                            exp_io, got_io);
                        err_enc++;
                    end
                end
                enc_idx++;
                if (tx_side && since_mark < 0) begin
                    since_mark = 0;         // looped back into the rx input
                end
            end else begin
                assert (got_io == '0) else begin
                    $display("ERR %0s: idle io word expected %h actual %h", v.name,
                        {IO_W{1'b0}}, got_io);
                    err_enc++;
                end
            end
            if (mac_rx_valid) begin
                assert (rcvd < v.exp_rx && rcvd < grants) else begin
                    $display("%0s: word reached the MAC without a credit or beyond the count",
                        v.name);
                    err_data++;
                end
                if (rcvd < v.exp_rx) begin
                    assert (mac_rx_data == words[rcvd]) else begin
                        $display("ERR %0s: rx word %0d expected %h actual %h", v.name, rcvd,
                            words[rcvd], mac_rx_data);
                        err_data++;
                    end
                end
                rcvd++;
            end

            // next cycle's inputs
            mac_tx_valid  = 1'b0;
            aibio_din     = '0;
            mac_rx_credit = 1'b0;
            if (sent < v.n_words && tx_side) begin
                if (tx_cred > 0 && ($random(seed) & 3) != 0) begin
                    mac_tx_valid = 1'b1;
                    mac_tx_data  = words[sent];
                    tx_cred--;
                    sent++;
                end
            end else if (sent < v.n_words && ($random(seed) & 1) != 0) begin
                aibio_din = dbi_encode(words[sent], v.dbi_en);  // idle words in between
                sent++;
                if (since_mark < 0) begin
                    since_mark = 0;
                end
            end
            if (sent == v.n_words && (!tx_side || enc_idx == v.n_words)) begin
                settle++;                   // last word is through the rx input stage
            end
            if (grants < v.n_words && (!v.hold_cred || settle > 3) && ($random(seed) & 1) != 0)
            begin
                mac_rx_credit = 1'b1;
                grants++;
            end
            if (grants == v.n_words) begin
                drain++;
            end
            done = (sent == v.n_words) && (rcvd == v.exp_rx) && (drain > 4) &&
                (tx_cred == TX_DEPTH);
            if (!done && cycles >= 600) begin
                $display("%0s: timeout with %0d of %0d words received", v.name, rcvd, v.exp_rx);
                err_ctrl++;
                timed_out = 1'b1;
            end
        end
        assert (rx_overflow == v.exp_ovf) else begin
            $display("ERR %0s: rx_overflow expected %0b actual %0b", v.name, v.exp_ovf,
                rx_overflow);
            err_ctrl++;
        end
        assert (m_rx_align_done) else begin
            $display("%0s: align flag never rose", v.name);
            err_ctrl++;
        end
        assert (tx_cred == TX_DEPTH) else begin
            $display("ERR %0s: tx credits expected %0d actual %0d", v.name, TX_DEPTH, tx_cred);
            err_ctrl++;
        end
        assert (enc_idx == (tx_side ? v.n_words : 0)) else begin
            $display("ERR %0s: marked io words expected %0d actual %0d", v.name,
                tx_side ? v.n_words : 0, enc_idx);
            err_enc++;
        end
    endtask

    initial begin
        reset         = 1'b1;
        mac_tx_valid  = 1'b0;
        mac_tx_data   = '0;
        aibio_din     = '0;
        mac_rx_credit = 1'b0;
        csr_tx_dbi_en = 1'b0;
        csr_rx_dbi_en = 1'b0;
        csr_lpbk_mode = 2'd0;
        seed          = 56632;
        err_data      = 0;
        err_enc       = 0;
        err_ctrl      = 0;
        timed_out     = 1'b0;
        for (int t = 0; t < num_tests && !timed_out; t++) begin
            run_test(test_table[t]);
        end
        $display("errors: rx data %0d, io encoding %0d, control %0d", err_data, err_enc,
            err_ctrl);
        if (err_data + err_enc + err_ctrl == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
verilog/aib_data_pkg.sv
verilog/aib_ctrl_pkg.sv
verilog/aib_word_fifo.sv
verilog/aib_tx_chnl.sv
verilog/aib_dbi_enc.sv
verilog/aib_rx_chnl.sv
verilog/aib_adapt_chnl.sv
test/aib_adapt_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the adapter channel testbench with Verilator and runs it
# the run passes only when the pass line appears in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module aib_adapt_tb -o aib_adapt_sim \
    && ./obj_dir/aib_adapt_sim | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
    || { echo "adapter channel run did not pass" >&2; exit 1; }
